// ==== common/cpu_decode_pkg.sv ====
package cpu_decode_pkg;

   // ************************************************************
   // widths and sizes.
   // ************************************************************
   localparam int data_w      = 16;
   localparam int alu_w       = 4;
   localparam int reg_n       = 8;
   localparam int reg_aw      = 3;
   localparam int queue_depth = 4;
   localparam int queue_aw    = 2;
   localparam int pend_max    = 3;
   localparam int pend_w      = 2;

   // ************************************************************
   // instruction field layout.
   // ************************************************************
   localparam int cls_msb  = 15;
   localparam int cls_lsb  = 14;
   localparam int ra_msb   = 13;
   localparam int ra_lsb   = 11;
   localparam int rb_msb   = 10;
   localparam int rb_lsb   = 8;
   localparam int func_msb = 7;
   localparam int func_lsb = 4;
   localparam int d_msb    = 3;
   localparam int d_lsb    = 0;
   localparam int imm8_msb = 7;    // imm8 is bits 7..0.
   localparam int joff_msb = 10;   // jump offset is bits 10..0.

   // class codes.
   localparam logic [1:0] cls_alu = 2'd0;
   localparam logic [1:0] cls_ldi = 2'd1;
   localparam logic [1:0] cls_mem = 2'd2;
   localparam logic [1:0] cls_ctl = 2'd3;

   localparam logic [alu_w-1:0]  mem_load  = 4'd0;   // func of a load.
   localparam logic [alu_w-1:0]  mem_store = 4'd1;
   localparam logic [reg_aw-1:0] ctl_jump  = 3'd0;   // ra field of a jump.
   localparam logic [reg_aw-1:0] ctl_halt  = 3'd7;

   // decoded operation as it leaves the decode stage.
   typedef struct packed {
      logic [alu_w-1:0]  alu_op;
      logic [data_w-1:0] src_a;
      logic [data_w-1:0] src_b;
      logic [data_w-1:0] imm;       // sext imm8 for ldi, zext d for mem.
      logic [reg_aw-1:0] dest;
      logic              reg_write;
      logic              mem_read;
      logic              mem_write;
      logic              is_halt;
      logic [data_w-1:0] pcinc;
      logic [7:0]        spare;     // room for the spare func value.
   } uop_t;

endpackage

// ==== common/fetch_if.sv ====
`timescale 1ns/1ns

// fetched word and its incremented pc under valid/ready.
interface fetch_if
   import cpu_decode_pkg::*;
();

   logic              valid;
   logic              ready;
   logic [data_w-1:0] inst;
   logic [data_w-1:0] pcinc;   // word address plus one.

   modport producer (output valid, output inst, output pcinc, input ready);
   modport consumer (input valid, input inst, input pcinc, output ready);

endinterface

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage
   import cpu_decode_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   fetch_if.consumer         inst_in,
   output uop_t              uop,
   output logic              uop_valid,
   input  logic              uop_ready,
   input  logic              wb_en,
   input  logic [reg_aw-1:0] wb_adr,
   input  logic [data_w-1:0] wb_dat,
   output logic              redirect,
   output logic [data_w-1:0] redirect_pc,
   output logic              halted
);

   logic [1:0]        cls;
   logic [reg_aw-1:0] ra;
   logic [reg_aw-1:0] rb;
   logic [alu_w-1:0]  func;
   logic [data_w-1:0] imm_s8;
   logic [data_w-1:0] imm_zd;
   logic [data_w-1:0] jump_off;
   logic [data_w-1:0] rd_dat_a;
   logic [data_w-1:0] rd_dat_b;
   logic [alu_w-1:0]  alu_op;
   logic [reg_aw-1:0] dest;
   logic [data_w-1:0] imm;
   logic              use_a;
   logic              use_b;
   logic              reg_write;
   logic              mem_read;
   logic              mem_write;
   logic              is_op;
   logic              is_jump;
   logic              is_halt;
   logic              hazard;
   logic              out_free;
   logic              accept;
   uop_t              op;

   // ************************************************************
   // fields and class decode.
   // ************************************************************
   assign cls      = inst_in.inst[cls_msb:cls_lsb];
   assign ra       = inst_in.inst[ra_msb:ra_lsb];
   assign rb       = inst_in.inst[rb_msb:rb_lsb];
   assign func     = inst_in.inst[func_msb:func_lsb];
   assign imm_s8   = {{(data_w-imm8_msb-1){inst_in.inst[imm8_msb]}}, inst_in.inst[imm8_msb:0]};
   assign imm_zd   = {{(data_w-d_msb-1){1'b0}}, inst_in.inst[d_msb:d_lsb]};
   assign jump_off = {{(data_w-joff_msb-1){inst_in.inst[joff_msb]}}, inst_in.inst[joff_msb:0]};

   always_comb begin
      use_a     = 1'b0;
      use_b     = 1'b0;
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      is_op     = 1'b0;
      is_jump   = 1'b0;
      is_halt   = 1'b0;
      alu_op    = '0;
      dest      = ra;
      imm       = '0;
      case (cls)
         cls_alu: begin   // ra <= ra op rb.
            use_a     = 1'b1;
            use_b     = 1'b1;
            reg_write = 1'b1;
            alu_op    = func;
            is_op     = 1'b1;
         end
         cls_ldi: begin
            dest      = rb;
            reg_write = 1'b1;
            imm       = imm_s8;
            is_op     = 1'b1;
         end
         cls_mem: begin
            imm = imm_zd;
            if (func == mem_load) begin
               use_a     = 1'b1;
               dest      = rb;
               reg_write = 1'b1;
               mem_read  = 1'b1;
               is_op     = 1'b1;
            end else if (func == mem_store) begin
               use_a     = 1'b1;
               use_b     = 1'b1;
               mem_write = 1'b1;
               is_op     = 1'b1;
            end
         end
         default: begin   // other control ra values do nothing.
            if (ra == ctl_jump) begin
               is_jump = 1'b1;
            end else if (ra == ctl_halt) begin
               is_halt = 1'b1;
               is_op   = 1'b1;
            end
         end
      endcase
   end

   regfile i_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_adr_a (ra),
      .rd_adr_b (rb),
      .rd_dat_a (rd_dat_a),
      .rd_dat_b (rd_dat_b),
      .wb_en    (wb_en),
      .wb_adr   (wb_adr),
      .wb_dat   (wb_dat)
   );

   reg_scoreboard i_scoreboard (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (accept && reg_write),
      .issue_dest (dest),
      .wb_en      (wb_en),
      .wb_adr     (wb_adr),
      .chk_a      (ra),
      .chk_b      (rb),
      .use_a      (use_a),
      .use_b      (use_b),
      .chk_dest   (dest),
      .use_dest   (reg_write),
      .hazard     (hazard)
   );

   always_comb begin
      op.alu_op    = alu_op;
      op.src_a     = use_a ? rd_dat_a : '0;
      op.src_b     = use_b ? rd_dat_b : '0;
      op.imm       = imm;
      op.dest      = reg_write ? dest : '0;
      op.reg_write = reg_write;
      op.mem_read  = mem_read;
      op.mem_write = mem_write;
      op.is_halt   = is_halt;
      op.pcinc     = inst_in.pcinc;
      op.spare     = '0;
   end

   // ************************************************************
   // issue control.
   // ************************************************************
   assign out_free = !uop_valid || uop_ready;
   // jumps and no-ops need no output slot.
   assign accept = inst_in.valid && !halted && !redirect && !hazard && (out_free || !is_op);
   assign inst_in.ready = accept;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         uop_valid <= 1'b0;
         redirect  <= 1'b0;
         halted    <= 1'b0;
      end else begin
         if (accept && is_op) uop_valid <= 1'b1;
         else if (uop_ready) uop_valid <= 1'b0;
         redirect <= accept && is_jump;   // one cycle pulse.
         if (accept && is_halt) halted <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && is_op) uop <= op;
      if (accept && is_jump) redirect_pc <= inst_in.pcinc + jump_off;
   end

   a_uop_hold: assert property (@(posedge clk) disable iff (!rst_n)
      uop_valid && !uop_ready |=> uop_valid && $stable(uop));

endmodule

// ==== decode/reg_scoreboard.sv ====
`timescale 1ns/1ns

module reg_scoreboard
   import cpu_decode_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              issue,
   input  logic [reg_aw-1:0] issue_dest,
   input  logic              wb_en,
   input  logic [reg_aw-1:0] wb_adr,
   input  logic [reg_aw-1:0] chk_a,
   input  logic [reg_aw-1:0] chk_b,
   input  logic              use_a,
   input  logic              use_b,
   input  logic [reg_aw-1:0] chk_dest,
   input  logic              use_dest,
   output logic              hazard
);

   logic [pend_w-1:0] pend [reg_n];   // writes issued and not yet back.
   logic [reg_n-1:0]  inc;
   logic [reg_n-1:0]  dec;
   logic [pend_w-1:0] left_a;
   logic [pend_w-1:0] left_b;
   logic [pend_w-1:0] left_dest;

   always_comb begin
      for (int i = 0; i < reg_n; i++) begin
         inc[i] = issue && issue_dest == reg_aw'(i);
         dec[i] = wb_en && wb_adr == reg_aw'(i);
      end
   end

   // counts as they stand once this cycle's write-back is in.
   assign left_a    = pend[chk_a] - pend_w'(dec[chk_a]);
   assign left_b    = pend[chk_b] - pend_w'(dec[chk_b]);
   assign left_dest = pend[chk_dest] - pend_w'(dec[chk_dest]);

   assign hazard = (use_a && left_a != '0) || (use_b && left_b != '0) ||
                   (use_dest && left_dest == pend_w'(pend_max));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_n; i++) begin
            pend[i] <= '0;
         end
      end else begin
         for (int i = 0; i < reg_n; i++) begin
            if (inc[i] && !dec[i]) pend[i] <= pend[i] + 1'b1;
            else if (dec[i] && !inc[i]) pend[i] <= pend[i] - 1'b1;
         end
      end
   end

   a_no_wb_unissued: assert property (@(posedge clk) disable iff (!rst_n)
      wb_en |-> pend[wb_adr] != '0);
   a_no_issue_full: assert property (@(posedge clk) disable iff (!rst_n)
      issue |-> pend[issue_dest] != pend_w'(pend_max) || dec[issue_dest]);

endmodule

// ==== decode/regfile.sv ====
`timescale 1ns/1ns

module regfile
   import cpu_decode_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [reg_aw-1:0] rd_adr_a,
   input  logic [reg_aw-1:0] rd_adr_b,
   output logic [data_w-1:0] rd_dat_a,
   output logic [data_w-1:0] rd_dat_b,
   input  logic              wb_en,
   input  logic [reg_aw-1:0] wb_adr,
   input  logic [data_w-1:0] wb_dat
);

   logic [data_w-1:0] regs [reg_n];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_n; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en) begin
         regs[wb_adr] <= wb_dat;
      end
   end

   // write-back in the same cycle wins over the stored value.
   assign rd_dat_a = (wb_en && wb_adr == rd_adr_a) ? wb_dat : regs[rd_adr_a];
   assign rd_dat_b = (wb_en && wb_adr == rd_adr_b) ? wb_dat : regs[rd_adr_b];

endmodule

// ==== flist.f ====
common/cpu_decode_pkg.sv
common/fetch_if.sv
hw/fetch_unit.sv
hw/inst_queue.sv
decode/regfile.sv
decode/reg_scoreboard.sv
decode/decode_stage.sv
hw/decode_top.sv
verif/decode_checker.sv
verif/tb_decode_top.sv

// ==== hw/decode_top.sv ====
`timescale 1ns/1ns

module decode_top
   import cpu_decode_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   output logic [data_w-1:0] imem_adr,
   input  logic [data_w-1:0] imem_dat,
   output logic              uop_valid,
   input  logic              uop_ready,
   output logic [alu_w-1:0]  uop_alu_op,
   output logic [data_w-1:0] uop_src_a,
   output logic [data_w-1:0] uop_src_b,
   output logic [data_w-1:0] uop_imm,
   output logic [reg_aw-1:0] uop_dest,
   output logic              uop_reg_write,
   output logic              uop_mem_read,
   output logic              uop_mem_write,
   output logic              uop_is_halt,
   output logic [data_w-1:0] uop_pcinc,
   input  logic              wb_en,
   input  logic [reg_aw-1:0] wb_adr,
   input  logic [data_w-1:0] wb_dat,
   output logic              halted,
   output logic              redirect,
   output logic [data_w-1:0] redirect_pc
);

   fetch_if f2q ();
   fetch_if q2d ();
   uop_t    uop;

   fetch_unit i_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .imem_adr    (imem_adr),
      .imem_dat    (imem_dat),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .fetch       (f2q.producer)
   );

   inst_queue i_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .redirect (redirect),
      .in_side  (f2q.consumer),
      .out_side (q2d.producer)
   );

   decode_stage i_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .inst_in     (q2d.consumer),
      .uop         (uop),
      .uop_valid   (uop_valid),
      .uop_ready   (uop_ready),
      .wb_en       (wb_en),
      .wb_adr      (wb_adr),
      .wb_dat      (wb_dat),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .halted      (halted)
   );

   // operation fields out to plain ports.
   assign uop_alu_op    = uop.alu_op;
   assign uop_src_a     = uop.src_a;
   assign uop_src_b     = uop.src_b;
   assign uop_imm       = uop.imm;
   assign uop_dest      = uop.dest;
   assign uop_reg_write = uop.reg_write;
   assign uop_mem_read  = uop.mem_read;
   assign uop_mem_write = uop.mem_write;
   assign uop_is_halt   = uop.is_halt;
   assign uop_pcinc     = uop.pcinc;

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit
   import cpu_decode_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   output logic [data_w-1:0] imem_adr,
   input  logic [data_w-1:0] imem_dat,
   input  logic              redirect,
   input  logic [data_w-1:0] redirect_pc,
   fetch_if.producer         fetch
);

   logic [data_w-1:0] pc;         // next address to request.
   logic [data_w-1:0] resp_pc;    // address of the word on imem_dat.
   logic              resp_vld;   // one request in flight.
   logic              stale;
   logic              advance;

   assign stale   = resp_vld & redirect;   // old path is dropped.
   assign advance = redirect | ~resp_vld | fetch.ready;

   // a held word keeps its address on the bus so memory repeats it.
   always_comb begin
      if (redirect) begin
         imem_adr = redirect_pc;
      end else if (advance) begin
         imem_adr = pc;
      end else begin
         imem_adr = resp_pc;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc       <= '0;
         resp_vld <= 1'b0;
      end else if (advance) begin
         pc       <= imem_adr + 1'b1;
         resp_vld <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         resp_pc <= imem_adr;
      end
   end

   assign fetch.valid = resp_vld & ~stale;
   assign fetch.inst  = imem_dat;
   assign fetch.pcinc = resp_pc + 1'b1;

   // queue is emptied with the drop, so the target word never waits.
   a_stale_then_room: assert property (@(posedge clk) disable iff (!rst_n)
      stale |=> !(fetch.valid && !fetch.ready));

endmodule

// ==== hw/inst_queue.sv ====
`timescale 1ns/1ns

module inst_queue
   import cpu_decode_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      redirect,
   fetch_if.consumer in_side,
   fetch_if.producer out_side
);

   logic [data_w-1:0]   inst_mem  [queue_depth];
   logic [data_w-1:0]   pcinc_mem [queue_depth];
   logic [queue_aw-1:0] wr_ptr;
   logic [queue_aw-1:0] rd_ptr;
   logic [queue_aw:0]   count;
   logic                push;
   logic                pop;

   assign in_side.ready  = (count != queue_depth);
   assign out_side.valid = (count != '0);
   assign out_side.inst  = inst_mem[rd_ptr];
   assign out_side.pcinc = pcinc_mem[rd_ptr];

   assign push = in_side.valid & in_side.ready;
   assign pop  = out_side.valid & out_side.ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (redirect) begin   // wrong-path words go.
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + {{queue_aw{1'b0}}, push} - {{queue_aw{1'b0}}, pop};
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         inst_mem[wr_ptr]  <= in_side.inst;
         pcinc_mem[wr_ptr] <= in_side.pcinc;
      end
   end

   // equal pointers mean empty or full, the count tells which.
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> wr_ptr != rd_ptr || count == '0);
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> wr_ptr != rd_ptr || count == queue_depth);

endmodule

// ==== verif/decode_checker.sv ====
`timescale 1ns/1ns

module decode_checker (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        uop_valid,
   input  logic        uop_ready,
   input  logic [3:0]  uop_alu_op,
   input  logic [15:0] uop_src_a,
   input  logic [15:0] uop_src_b,
   input  logic [15:0] uop_imm,
   input  logic [2:0]  uop_dest,
   input  logic        uop_reg_write,
   input  logic        uop_mem_read,
   input  logic        uop_mem_write,
   input  logic        uop_is_halt,
   input  logic [15:0] uop_pcinc,
   input  logic        halted,
   input  logic        redirect,
   input  logic [15:0] redirect_pc,
   input  logic        end_check,
   output int          err_cnt,
   output int          ops_seen,
   output int          redir_seen,
   output logic        halt_seen
);

   localparam int op_n    = 10;
   localparam int redir_n = 2;

   typedef struct packed {
      logic [3:0]  alu_op;
      logic [15:0] src_a;
      logic [15:0] src_b;
      logic [15:0] imm;
      logic [2:0]  dest;
      logic        reg_write;
      logic        mem_read;
      logic        mem_write;
      logic        is_halt;
      logic [15:0] pcinc;
   } op_fields_t;

   op_fields_t  exp_tab [op_n];
   logic [15:0] redir_tab [redir_n];
   op_fields_t  got;
   op_fields_t  held;
   logic        was_held = 1'b0;
   logic        was_redirect = 1'b0;
   logic        was_halted = 1'b0;
   logic        first_edge = 1'b1;
   logic        end_done = 1'b0;

   assign got = {uop_alu_op, uop_src_a, uop_src_b, uop_imm, uop_dest, uop_reg_write,
                 uop_mem_read, uop_mem_write, uop_is_halt, uop_pcinc};

   initial begin
      err_cnt    = 0;
      ops_seen   = 0;
      redir_seen = 0;
      halt_seen  = 1'b0;
      // alu_op, src_a, src_b, imm, dest, {write, load, store, halt}, pcinc
      exp_tab[0] = {4'h0, 16'h0000, 16'h0000, 16'h0005, 3'd1, 4'b1000, 16'd1};
      exp_tab[1] = {4'h0, 16'h0000, 16'h0000, 16'hfffe, 3'd2, 4'b1000, 16'd2};
      exp_tab[2] = {4'h3, 16'h0005, 16'hfffe, 16'h0000, 3'd1, 4'b1000, 16'd3};
      exp_tab[3] = {4'h0, 16'h1234, 16'h0000, 16'h0007, 3'd3, 4'b1100, 16'd4};
      exp_tab[4] = {4'h0, 16'hfffe, 16'hbeef, 16'h000a, 3'd0, 4'b0010, 16'd5};
      exp_tab[5] = {4'hf, 16'h0000, 16'h0000, 16'h0000, 3'd4, 4'b1000, 16'd11};
      exp_tab[6] = {4'h2, 16'h0f0f, 16'hbeef, 16'h0000, 3'd4, 4'b1000, 16'd12};
      exp_tab[7] = {4'h0, 16'h0000, 16'h0000, 16'hff80, 3'd5, 4'b1000, 16'd13};
      exp_tab[8] = {4'h0, 16'hff80, 16'h00aa, 16'h0000, 3'd0, 4'b0010, 16'd17};
      exp_tab[9] = {4'h0, 16'h0000, 16'h0000, 16'h0000, 3'd0, 4'b0001, 16'd18};
      redir_tab[0] = 16'd9;    // 6 plus 3.
      redir_tab[1] = 16'd16;
   end

   task automatic compare_field(input string name, input logic [15:0] got_v,
                                input logic [15:0] exp_v);
      if (got_v !== exp_v) begin
         err_cnt++;
         $display("ERR %0t: operation %0d %s is %h, expected %h",
                  $time, ops_seen, name, got_v, exp_v);
      end
   endtask

   task automatic score_op();
      if (ops_seen >= op_n) begin
         err_cnt++;
         $display("ERR %0t: extra operation with pcinc %h", $time, got.pcinc);
      end else begin
         compare_field("alu_op", got.alu_op, exp_tab[ops_seen].alu_op);
         compare_field("src_a", got.src_a, exp_tab[ops_seen].src_a);
         compare_field("src_b", got.src_b, exp_tab[ops_seen].src_b);
         compare_field("imm", got.imm, exp_tab[ops_seen].imm);
         compare_field("dest", got.dest, exp_tab[ops_seen].dest);
         compare_field("reg_write", got.reg_write, exp_tab[ops_seen].reg_write);
         compare_field("mem_read", got.mem_read, exp_tab[ops_seen].mem_read);
         compare_field("mem_write", got.mem_write, exp_tab[ops_seen].mem_write);
         compare_field("is_halt", got.is_halt, exp_tab[ops_seen].is_halt);
         compare_field("pcinc", got.pcinc, exp_tab[ops_seen].pcinc);
         compare_field("halted", halted, exp_tab[ops_seen].is_halt);   // rises with the halt.
         if (exp_tab[ops_seen].is_halt) begin
            halt_seen = 1'b1;
         end
      end
      ops_seen++;
   endtask

   task automatic match_redirect();
      if (was_redirect) begin
         err_cnt++;
         $display("ERR %0t: redirect high for a second cycle", $time);
      end
      if (redir_seen >= redir_n) begin
         err_cnt++;
         $display("ERR %0t: extra redirect to %h", $time, redirect_pc);
      end else if (redirect_pc !== redir_tab[redir_seen]) begin
         err_cnt++;
         $display("ERR %0t: redirect %0d to %h, expected %h",
                  $time, redir_seen, redirect_pc, redir_tab[redir_seen]);
      end
      redir_seen++;
   endtask

   // ************************************************************
   // per-cycle monitor.
   // ************************************************************
   always @(posedge clk) begin
      if (!rst_n) begin
         first_edge = 1'b1;
      end else begin
         if (first_edge && (uop_valid !== 1'b0 || redirect !== 1'b0 || halted !== 1'b0)) begin
            err_cnt++;
            $display("ERR %0t: outputs not idle after reset", $time);
         end
         first_edge = 1'b0;
         if (was_held && (uop_valid !== 1'b1 || got !== held)) begin
            err_cnt++;
            $display("ERR %0t: held operation changed before it was taken", $time);
         end
         if (uop_valid && uop_ready) score_op();
         if (redirect) match_redirect();
         if (was_halted && !halted) begin
            err_cnt++;
            $display("ERR %0t: halted dropped before reset", $time);
         end
         was_held     = uop_valid && !uop_ready;
         held         = got;
         was_redirect = redirect;
         was_halted   = halted;
         if (end_check && !end_done) begin
            end_done = 1'b1;
            if (ops_seen != op_n) begin
               err_cnt++;
               $display("ERR %0t: %0d operations seen, expected %0d", $time, ops_seen, op_n);
            end
            if (redir_seen != redir_n) begin
               err_cnt++;
               $display("ERR %0t: %0d redirects seen, expected %0d", $time, redir_seen, redir_n);
            end
            if (halted !== 1'b1) begin
               err_cnt++;
               $display("ERR %0t: halted is low at the end of the run", $time);
            end
         end
      end
   end

endmodule

// ==== verif/tb_decode_top.sv ====
`timescale 1ns/1ns

module tb_decode_top;

   localparam int wb_n     = 7;
   localparam int wait_max = 200;
   localparam int op_limit = 40;   // runaway output ends the run.

   logic        clk = 1'b0;
   logic        rst_n;
   logic [15:0] imem_adr;
   logic [15:0] imem_dat;
   logic        uop_valid;
   logic        uop_ready;
   logic [3:0]  uop_alu_op;
   logic [15:0] uop_src_a;
   logic [15:0] uop_src_b;
   logic [15:0] uop_imm;
   logic [2:0]  uop_dest;
   logic        uop_reg_write;
   logic        uop_mem_read;
   logic        uop_mem_write;
   logic        uop_is_halt;
   logic [15:0] uop_pcinc;
   logic        wb_en;
   logic [2:0]  wb_adr;
   logic [15:0] wb_dat;
   logic        halted;
   logic        redirect;
   logic [15:0] redirect_pc;
   logic        end_check = 1'b0;
   int          err_cnt;
   int          ops_seen;
   int          redir_seen;
   logic        halt_seen;

   logic [15:0] prog [32];
   logic [18:0] wb_tab [wb_n];   // register and value of each writer in order.
   int          writers_seen = 0;
   int          seed_draw;
   logic        wb_done = 1'b0;
   logic        timed_out = 1'b0;

   decode_top i_dut (.*);

   decode_checker i_chk (.*);

   always #4 clk = ~clk;

   // ************************************************************
   // program and write-back tables.
   // ************************************************************
   initial begin
      for (int i = 18; i < 32; i++) begin
         prog[i] = 16'h4600 | 16'(i);   // ldi r6 past the halt.
      end
      prog[0]  = 16'h4105;   // ldi r1, 5.
      prog[1]  = 16'h42fe;   // ldi r2, -2.
      prog[2]  = 16'h0a30;   // alu r1, r2, func 3.
      prog[3]  = 16'h8b07;   // load r3, 7(r1).
      prog[4]  = 16'h931a;   // store r3, 10(r2).
      prog[5]  = 16'hc003;   // jump to 9.
      prog[6]  = 16'h4711;   // wrong path.
      prog[7]  = 16'h4722;
      prog[8]  = 16'h4733;
      prog[9]  = 16'hd800;   // control no-op.
      prog[10] = 16'h24f0;   // alu r4, r4, func f.
      prog[11] = 16'h2320;   // alu r4, r3, func 2 stalls on r4.
      prog[12] = 16'h4580;   // ldi r5, -128.
      prog[13] = 16'hc002;   // jump to 16.
      prog[14] = 16'h4744;
      prog[15] = 16'h4755;
      prog[16] = 16'hac10;   // store r4, 0(r5).
      prog[17] = 16'hf800;   // halt.
      wb_tab[0] = {3'd1, 16'h0005};
      wb_tab[1] = {3'd2, 16'hfffe};
      wb_tab[2] = {3'd1, 16'h1234};
      wb_tab[3] = {3'd3, 16'hbeef};
      wb_tab[4] = {3'd4, 16'h0f0f};
      wb_tab[5] = {3'd4, 16'h00aa};
      wb_tab[6] = {3'd5, 16'hff80};
   end

   // instruction memory returns data one cycle after the address.
   initial begin
      imem_dat = '0;
      forever begin
         @(posedge clk);
         imem_dat <= prog[imem_adr[4:0]];
      end
   end

   initial begin
      uop_ready = 1'b0;
      forever begin
         @(posedge clk);
         uop_ready <= ($urandom % 3) != 0;
      end
   end

   always @(posedge clk) begin
      if (rst_n && uop_valid && uop_ready && uop_reg_write) begin
         writers_seen <= writers_seen + 1;
      end
   end

   // ************************************************************
   // write-back driver.
   // ************************************************************
   initial begin : wb_driver
      int   cnt;
      int   delay;
      logic gave_up;
      wb_en   = 1'b0;
      wb_adr  = '0;
      wb_dat  = '0;
      gave_up = 1'b0;
      for (int k = 0; k < wb_n && !gave_up; k++) begin
         cnt = 0;
         while (writers_seen <= k && cnt < wait_max) begin
            @(posedge clk);
            cnt++;
         end
         if (writers_seen <= k) begin
            gave_up = 1'b1;
            $display("write-back driver gave up, writer %0d was never accepted", k);
         end else begin
            delay = $urandom % 6;
            repeat (delay) @(posedge clk);
            wb_en  <= 1'b1;
            wb_adr <= wb_tab[k][18:16];
            wb_dat <= wb_tab[k][15:0];
            @(posedge clk);
            wb_en <= 1'b0;
         end
      end
      wb_done = !gave_up;
   end

   initial begin : main_flow
      int idle;
      int last_seen;
      rst_n     = 1'b0;
      seed_draw = $urandom(32'he4424ba0);
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      idle      = 0;
      last_seen = 0;
      while (!halt_seen && !timed_out && ops_seen < op_limit) begin
         @(negedge clk);
         idle++;
         if (ops_seen != last_seen) begin
            last_seen = ops_seen;
            idle      = 0;
         end
         if (idle >= wait_max) begin
            timed_out = 1'b1;
            $display("timeout, no operation left the DUT for %0d cycles", wait_max);
         end
      end
      if (!timed_out) begin
         repeat (50) @(negedge clk);   // nothing may follow the halt.
         idle = 0;
         while (!wb_done && !timed_out) begin
            @(negedge clk);
            idle++;
            if (idle >= wait_max) begin
               timed_out = 1'b1;
               $display("timeout, write-backs did not finish");
            end
         end
      end
      end_check <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      $display("operations %0d redirects %0d errors %0d", ops_seen, redir_seen, err_cnt);
      if (timed_out || err_cnt != 0) begin
         $display("Some tests failed");
      end else begin
         $display("All tests passed");
      end
      $finish;
   end

endmodule
